// File: rtl/board_pkg.sv
package board_pkg;

	// memory bus widths
	localparam int MEM_DATA_W    = 32;
	localparam int MEM_ADDR_W    = 26;
	localparam int LOADER_ADDR_W = 24;
	localparam int MEM_SEL_W     = 4;

	// video
	localparam int COLOR_W = 4;

	// joysticks, host side and core side
	localparam int JOY_W      = 8;
	localparam int CORE_JOY_W = 5;

	// data_io download indices
	localparam int DIO_INDEX_W = 8;
	localparam logic [DIO_INDEX_W-1:0] DIO_ROM_A = 8'd1;
	localparam logic [DIO_INDEX_W-1:0] DIO_ROM_B = 8'd2;
	localparam logic [DIO_INDEX_W-1:0] DIO_CMOS  = 8'd3;

	// busy timeout after a reconfigure pulse, in clk_sys cycles
	localparam int RECONFIG_TIMEOUT = 1000;
	localparam int RECONFIG_TMO_W   = $clog2(RECONFIG_TIMEOUT + 1);

	// back porch blank counter
	localparam int BLANK_CNT_W = 8;
	// low slice used in VGA modes, 64 counts
	localparam int BLANK_VGA_W = 6;

	// video base clock select from the core
	// equal bits mean TV-rate 24 MHz
	typedef enum logic [1:0] {
		CLK_24M     = 2'b00,
		CLK_25M     = 2'b01,
		CLK_36M     = 2'b10,
		CLK_24M_ALT = 2'b11
	} clksel_t;

	typedef enum logic [1:0] {
		RC_IDLE = 2'b00,
		RC_LOAD = 2'b01,
		RC_ARM  = 2'b10,
		RC_WAIT = 2'b11
	} reconfig_state_t;

endpackage

// File: rtl/pll_reconfig_seq.sv
module pll_reconfig_seq
	import board_pkg::*;
(
	input  logic    clk_sys,
	input  logic    rst_i,
	input  clksel_t clk_sel_i,
	input  logic    busy_i,
	output logic    write_from_rom_o,
	output logic    reconfig_o,
	output logic    reconfig_reset_o
);

	reconfig_state_t state;
	clksel_t clk_sel_q;
	logic [RECONFIG_TMO_W-1:0] timeout;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state            <= RC_IDLE;
			clk_sel_q        <= CLK_24M;
			timeout          <= '0;
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;
		end else begin
			// all three outputs are single cycle strobes
			write_from_rom_o <= 1'b0;
			reconfig_o       <= 1'b0;
			reconfig_reset_o <= 1'b0;

			case (state)
			RC_IDLE: begin
				// select only tracked while idle, a change mid-sequence
				// is picked up once we are back here
				clk_sel_q <= clk_sel_i;
				if (clk_sel_q != clk_sel_i) begin
					write_from_rom_o <= 1'b1;
					state            <= RC_LOAD;
				end
			end

			// let the block see the table write request
			RC_LOAD: state <= RC_ARM;

			RC_ARM: begin
				if (!busy_i) begin
					reconfig_o <= 1'b1;
					timeout    <= RECONFIG_TMO_W'(RECONFIG_TIMEOUT);
					state      <= RC_WAIT;
				end
			end

			RC_WAIT: begin
				timeout <= timeout - 1'b1;
				// stuck busy, kick the reconfig block
				if (timeout == RECONFIG_TMO_W'(1)) begin
					reconfig_reset_o <= 1'b1;
					state            <= RC_IDLE;
				end
				// skip the pulse cycle itself, busy lags it
				if (!reconfig_o && !busy_i)
					state <= RC_IDLE;
			end

			default: state <= RC_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/back_porch_blank.sv
module back_porch_blank
	import board_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst_i,
	input  logic               ce_pix_i,
	input  clksel_t            clk_sel_i,
	input  logic [COLOR_W-1:0] r_i,
	input  logic [COLOR_W-1:0] g_i,
	input  logic [COLOR_W-1:0] b_i,
	input  logic               hs_i,
	input  logic               vs_i,
	output logic [COLOR_W-1:0] r_o,
	output logic [COLOR_W-1:0] g_o,
	output logic [COLOR_W-1:0] b_o,
	output logic               hs_o,
	output logic               vs_o
);

	logic [BLANK_CNT_W-1:0] pix_cnt;
	logic tv_mode;
	logic cnt_sat;

	// 256 clocks in TV mode, 64 in the VGA modes
	assign tv_mode = (clk_sel_i[0] == clk_sel_i[1]);
	assign cnt_sat = tv_mode ? &pix_cnt : &pix_cnt[BLANK_VGA_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			pix_cnt <= '0;
			hs_o    <= 1'b0;
			vs_o    <= 1'b0;
			r_o     <= '0;
			g_o     <= '0;
			b_o     <= '0;
		end else begin
			// counts every clock, not just on pixel enables
			if (!hs_o)
				pix_cnt <= '0;
			else if (!cnt_sat)
				pix_cnt <= pix_cnt + 1'b1;

			if (ce_pix_i) begin
				hs_o <= hs_i;
				vs_o <= vs_i;
				if (cnt_sat) begin
					r_o <= r_i;
					g_o <= g_i;
					b_o <= b_i;
				end else begin
					// inside back porch, force black
					r_o <= '0;
					g_o <= '0;
					b_o <= '0;
				end
			end
		end
	end

endmodule

// File: rtl/loader_mem_arb.sv
module loader_mem_arb
	import board_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst_i,
	input  logic                     downloading_i,
	input  logic [DIO_INDEX_W-1:0]   dio_index_i,
	// loader write side
	input  logic                     loader_we_i,
	input  logic [LOADER_ADDR_W-1:0] loader_addr_i,
	input  logic [MEM_SEL_W-1:0]     loader_sel_i,
	input  logic [MEM_DATA_W-1:0]    loader_data_i,
	// core bus
	input  logic                     core_we_i,
	input  logic                     core_stb_i,
	input  logic [MEM_SEL_W-1:0]     core_sel_i,
	input  logic [LOADER_ADDR_W-1:0] core_addr_i,
	input  logic [MEM_DATA_W-1:0]    core_data_i,
	output logic                     core_ack_o,
	// ram bus
	input  logic                     ram_ack_i,
	input  logic                     ram_ready_i,
	output logic                     ram_we_o,
	output logic                     ram_stb_o,
	output logic                     ram_cyc_o,
	output logic [MEM_SEL_W-1:0]     ram_sel_o,
	output logic [MEM_ADDR_W-1:0]    ram_addr_o,
	output logic [MEM_DATA_W-1:0]    ram_data_o,
	output logic                     core_reset_o
);

	logic loader_active;
	logic loader_active_q;
	logic loader_stb;
	logic rom_ready;

	// only ROM images go through the ram bus, CMOS is handled elsewhere
	assign loader_active = downloading_i &&
		(dio_index_i == DIO_ROM_A || dio_index_i == DIO_ROM_B);

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			loader_active_q <= 1'b0;
			loader_stb      <= 1'b0;
			rom_ready       <= 1'b0;
		end else begin
			loader_active_q <= loader_active;
			// end of the ROM download releases the core
			if (loader_active_q && !loader_active)
				rom_ready <= 1'b1;
			// new write wins over an ack in the same cycle
			if (loader_we_i)
				loader_stb <= 1'b1;
			else if (ram_ack_i)
				loader_stb <= 1'b0;
		end
	end

	// word aligned addresses on both sides
	assign ram_we_o   = loader_active ? 1'b1 : core_we_i;
	assign ram_sel_o  = loader_active ? loader_sel_i : core_sel_i;
	assign ram_addr_o = loader_active ?
		MEM_ADDR_W'({loader_addr_i[LOADER_ADDR_W-1:2], 2'b00}) :
		MEM_ADDR_W'({core_addr_i[LOADER_ADDR_W-1:2], 2'b00});
	assign ram_stb_o  = loader_active ? loader_stb : core_stb_i;
	assign ram_cyc_o  = loader_active ? loader_stb : core_stb_i;
	assign ram_data_o = loader_active ? loader_data_i : core_data_i;
	assign core_ack_o = loader_active ? 1'b0 : ram_ack_i;

	assign core_reset_o = !ram_ready_i || !rom_ready;

endmodule

// File: rtl/mist_io_glue.sv
module mist_io_glue
	import board_pkg::*;
(
	// spi
	input  logic                   conf_ss_n_i,
	input  logic                   dio_ss_n_i,
	input  logic                   sd_ss_n_i,
	input  logic                   spi_di_i,
	input  logic                   user_sdo_i,
	input  logic                   dio_sdo_i,
	output logic                   spi_do_o,
	output logic                   spi_do_oe_o,
	output logic                   sd_sdi_o,
	// joysticks
	input  logic [JOY_W-1:0]       joy_a_i,
	input  logic [JOY_W-1:0]       joy_b_i,
	output logic [CORE_JOY_W-1:0]  core_joy0_o,
	output logic [CORE_JOY_W-1:0]  core_joy1_o,
	// cmos access
	input  logic                   downloading_i,
	input  logic                   uploading_i,
	input  logic [DIO_INDEX_W-1:0] dio_index_i,
	input  logic                   loader_we_i,
	output logic                   cmos_we_o,
	output logic                   cmos_rd_o,
	// video mode
	input  clksel_t                clk_sel_i,
	input  logic                   scandoubler_disable_i,
	output logic                   scandoubler_en_o
);

	// host order is right/left/down/up/fire, core wants fire first,
	// active low
	function automatic logic [CORE_JOY_W-1:0] remap_joy(input logic [JOY_W-1:0] joy);
		return ~{joy[4], joy[0], joy[1], joy[2], joy[3]};
	endfunction

	// user_io has priority over data_io
	assign spi_do_o    = !conf_ss_n_i ? user_sdo_i : (!dio_ss_n_i ? dio_sdo_i : 1'b0);
	assign spi_do_oe_o = !conf_ss_n_i || !dio_ss_n_i;

	// direct SD mode feeds data_io from the card's output
	assign sd_sdi_o = sd_ss_n_i ? spi_di_i : spi_do_o;

	// ports swapped on purpose
	assign core_joy0_o = remap_joy(joy_b_i);
	assign core_joy1_o = remap_joy(joy_a_i);

	assign cmos_we_o = downloading_i && (dio_index_i == DIO_CMOS) && loader_we_i;
	assign cmos_rd_o = uploading_i && (dio_index_i == DIO_CMOS);

	assign scandoubler_en_o = !scandoubler_disable_i && (clk_sel_i[0] == clk_sel_i[1]);

endmodule

// File: rtl/archimedes_board_glue.sv
module archimedes_board_glue
	import board_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst_i,
	input  clksel_t                  clk_sel_i,
	// pll reconfiguration block
	input  logic                     pll_busy_i,
	output logic                     pll_write_from_rom_o,
	output logic                     pll_reconfig_o,
	output logic                     pll_reconfig_reset_o,
	// core video in, blanked video out
	input  logic                     ce_pix_i,
	input  logic [COLOR_W-1:0]       core_r_i,
	input  logic [COLOR_W-1:0]       core_g_i,
	input  logic [COLOR_W-1:0]       core_b_i,
	input  logic                     core_hs_i,
	input  logic                     core_vs_i,
	output logic [COLOR_W-1:0]       vid_r_o,
	output logic [COLOR_W-1:0]       vid_g_o,
	output logic [COLOR_W-1:0]       vid_b_o,
	output logic                     vid_hs_o,
	output logic                     vid_vs_o,
	// data_io
	input  logic                     downloading_i,
	input  logic                     uploading_i,
	input  logic [DIO_INDEX_W-1:0]   dio_index_i,
	input  logic                     loader_we_i,
	input  logic [LOADER_ADDR_W-1:0] loader_addr_i,
	input  logic [MEM_SEL_W-1:0]     loader_sel_i,
	input  logic [MEM_DATA_W-1:0]    loader_data_i,
	// core memory bus
	input  logic                     core_we_i,
	input  logic                     core_stb_i,
	input  logic [MEM_SEL_W-1:0]     core_sel_i,
	input  logic [LOADER_ADDR_W-1:0] core_addr_i,
	input  logic [MEM_DATA_W-1:0]    core_data_i,
	output logic                     core_ack_o,
	output logic                     core_reset_o,
	// sdram bus
	input  logic                     ram_ack_i,
	input  logic                     ram_ready_i,
	output logic                     ram_we_o,
	output logic                     ram_stb_o,
	output logic                     ram_cyc_o,
	output logic [MEM_SEL_W-1:0]     ram_sel_o,
	output logic [MEM_ADDR_W-1:0]    ram_addr_o,
	output logic [MEM_DATA_W-1:0]    ram_data_o,
	// host spi
	input  logic                     conf_ss_n_i,
	input  logic                     dio_ss_n_i,
	input  logic                     sd_ss_n_i,
	input  logic                     spi_di_i,
	input  logic                     user_sdo_i,
	input  logic                     dio_sdo_i,
	output logic                     spi_do_o,
	output logic                     spi_do_oe_o,
	output logic                     sd_sdi_o,
	// joysticks, cmos, scandoubler
	input  logic [JOY_W-1:0]         joy_a_i,
	input  logic [JOY_W-1:0]         joy_b_i,
	output logic [CORE_JOY_W-1:0]    core_joy0_o,
	output logic [CORE_JOY_W-1:0]    core_joy1_o,
	output logic                     cmos_we_o,
	output logic                     cmos_rd_o,
	input  logic                     scandoubler_disable_i,
	output logic                     scandoubler_en_o
);

	pll_reconfig_seq u_pll_reconfig_seq (
		.clk_sys          (clk_sys),
		.rst_i            (rst_i),
		.clk_sel_i        (clk_sel_i),
		.busy_i           (pll_busy_i),
		.write_from_rom_o (pll_write_from_rom_o),
		.reconfig_o       (pll_reconfig_o),
		.reconfig_reset_o (pll_reconfig_reset_o)
	);

	back_porch_blank u_back_porch_blank (
		.clk_sys   (clk_sys),
		.rst_i     (rst_i),
		.ce_pix_i  (ce_pix_i),
		.clk_sel_i (clk_sel_i),
		.r_i       (core_r_i),
		.g_i       (core_g_i),
		.b_i       (core_b_i),
		.hs_i      (core_hs_i),
		.vs_i      (core_vs_i),
		.r_o       (vid_r_o),
		.g_o       (vid_g_o),
		.b_o       (vid_b_o),
		.hs_o      (vid_hs_o),
		.vs_o      (vid_vs_o)
	);

	loader_mem_arb u_loader_mem_arb (
		.clk_sys       (clk_sys),
		.rst_i         (rst_i),
		.downloading_i (downloading_i),
		.dio_index_i   (dio_index_i),
		.loader_we_i   (loader_we_i),
		.loader_addr_i (loader_addr_i),
		.loader_sel_i  (loader_sel_i),
		.loader_data_i (loader_data_i),
		.core_we_i     (core_we_i),
		.core_stb_i    (core_stb_i),
		.core_sel_i    (core_sel_i),
		.core_addr_i   (core_addr_i),
		.core_data_i   (core_data_i),
		.core_ack_o    (core_ack_o),
		.ram_ack_i     (ram_ack_i),
		.ram_ready_i   (ram_ready_i),
		.ram_we_o      (ram_we_o),
		.ram_stb_o     (ram_stb_o),
		.ram_cyc_o     (ram_cyc_o),
		.ram_sel_o     (ram_sel_o),
		.ram_addr_o    (ram_addr_o),
		.ram_data_o    (ram_data_o),
		.core_reset_o  (core_reset_o)
	);

	mist_io_glue u_mist_io_glue (
		.conf_ss_n_i           (conf_ss_n_i),
		.dio_ss_n_i            (dio_ss_n_i),
		.sd_ss_n_i             (sd_ss_n_i),
		.spi_di_i              (spi_di_i),
		.user_sdo_i            (user_sdo_i),
		.dio_sdo_i             (dio_sdo_i),
		.spi_do_o              (spi_do_o),
		.spi_do_oe_o           (spi_do_oe_o),
		.sd_sdi_o              (sd_sdi_o),
		.joy_a_i               (joy_a_i),
		.joy_b_i               (joy_b_i),
		.core_joy0_o           (core_joy0_o),
		.core_joy1_o           (core_joy1_o),
		.downloading_i         (downloading_i),
		.uploading_i           (uploading_i),
		.dio_index_i           (dio_index_i),
		.loader_we_i           (loader_we_i),
		.cmos_we_o             (cmos_we_o),
		.cmos_rd_o             (cmos_rd_o),
		.clk_sel_i             (clk_sel_i),
		.scandoubler_disable_i (scandoubler_disable_i),
		.scandoubler_en_o      (scandoubler_en_o)
	);

endmodule

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

	int stim_fd;
	string vec_name;
	string vec_kind;
	logic [31:0] f [0:21];

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic open_stim();
		stim_fd = $fopen("tb/stim_input.txt", "r");
		if (stim_fd == 0) begin
			$display("error: could not open the stimulus file tb/stim_input.txt");
			abort_run();
		end
	endtask

	// next data line into vec_name, vec_kind and f, comments and blanks skipped
	task automatic next_vector(output bit found);
		string line;
		int n;
		found = 0;
		while (!found && !$feof(stim_fd)) begin
			n = $fgets(line, stim_fd);
			if (n > 1 && line[0] != "#") begin
				n = $sscanf(line,
					"%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					vec_name, vec_kind, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
					f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
					f[18], f[19], f[20], f[21]);
				found = (n >= 2);
			end
		end
	endtask

	task automatic apply_bus_vector();
		logic [31:0] ldata, cdata;
		ldata = $urandom;
		cdata = $urandom;
		downloading_i = f[0][0];
		dio_index_i = f[1][DIO_INDEX_W-1:0];
		loader_addr_i = f[2][LOADER_ADDR_W-1:0];
		loader_sel_i = f[3][MEM_SEL_W-1:0];
		core_addr_i = f[4][LOADER_ADDR_W-1:0];
		core_sel_i = f[5][MEM_SEL_W-1:0];
		core_we_i = f[6][0];
		core_stb_i = f[7][0];
		loader_data_i = ldata;
		core_data_i = cdata;
		loader_we_i = 1'b0;
		ram_ack_i = 1'b1;
		@(negedge clk_sys);
		check({vec_name, " addr"}, f[8], ram_addr_o);
		check({vec_name, " sel"}, f[9], ram_sel_o);
		check({vec_name, " we"}, f[10], ram_we_o);
		check({vec_name, " stb"}, f[11], ram_stb_o);
		check({vec_name, " cyc"}, f[11], ram_cyc_o);
		check({vec_name, " ack"}, f[12], core_ack_o);
		check({vec_name, " data"}, f[13][0] ? ldata : cdata, ram_data_o);
	endtask

	task automatic apply_host_vector();
		{conf_ss_n_i, dio_ss_n_i, sd_ss_n_i} = {f[0][0], f[1][0], f[2][0]};
		{spi_di_i, user_sdo_i, dio_sdo_i} = {f[3][0], f[4][0], f[5][0]};
		joy_a_i = f[6][JOY_W-1:0];
		joy_b_i = f[7][JOY_W-1:0];
		{downloading_i, uploading_i} = {f[8][0], f[9][0]};
		dio_index_i = f[10][DIO_INDEX_W-1:0];
		loader_we_i = f[11][0];
		clk_sel_i = clksel_t'(f[12][1:0]);
		scandoubler_disable_i = f[13][0];
		@(negedge clk_sys);
		check({vec_name, " spi_do"}, f[14], spi_do_o);
		check({vec_name, " spi_oe"}, f[15], spi_do_oe_o);
		check({vec_name, " sd_sdi"}, f[16], sd_sdi_o);
		check({vec_name, " joy0"}, f[17], core_joy0_o);
		check({vec_name, " joy1"}, f[18], core_joy1_o);
		check({vec_name, " cmos_we"}, f[19], cmos_we_o);
		check({vec_name, " cmos_rd"}, f[20], cmos_rd_o);
		check({vec_name, " sd_en"}, f[21], scandoubler_en_o);
	endtask

`endif

// File: tb/tb_archimedes_board_glue.sv
module tb_archimedes_board_glue
	import board_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	// rough cycle budget of each test, the watchdog adds slack on top
	localparam int VEC_CYCLES   = 100;
	localparam int STB_CYCLES   = 50;
	localparam int PLL_CYCLES   = RECONFIG_TIMEOUT + 600;
	localparam int BLANK_CYCLES = 700;
	localparam int TOTAL_CYCLES = VEC_CYCLES + STB_CYCLES + PLL_CYCLES + BLANK_CYCLES + 2000;

	logic clk_sys;
	logic rst_i;
	clksel_t clk_sel_i;
	logic pll_busy_i, pll_write_from_rom_o, pll_reconfig_o, pll_reconfig_reset_o;
	logic ce_pix_i, core_hs_i, core_vs_i, vid_hs_o, vid_vs_o;
	logic [COLOR_W-1:0] core_r_i, core_g_i, core_b_i, vid_r_o, vid_g_o, vid_b_o;
	logic downloading_i, uploading_i, loader_we_i;
	logic [DIO_INDEX_W-1:0] dio_index_i;
	logic [LOADER_ADDR_W-1:0] loader_addr_i, core_addr_i;
	logic [MEM_SEL_W-1:0] loader_sel_i, core_sel_i, ram_sel_o;
	logic [MEM_DATA_W-1:0] loader_data_i, core_data_i, ram_data_o;
	logic core_we_i, core_stb_i, core_ack_o, core_reset_o;
	logic ram_ack_i, ram_ready_i, ram_we_o, ram_stb_o, ram_cyc_o;
	logic [MEM_ADDR_W-1:0] ram_addr_o;
	logic conf_ss_n_i, dio_ss_n_i, sd_ss_n_i, spi_di_i, user_sdo_i, dio_sdo_i;
	logic spi_do_o, spi_do_oe_o, sd_sdi_o;
	logic [JOY_W-1:0] joy_a_i, joy_b_i;
	logic [CORE_JOY_W-1:0] core_joy0_o, core_joy1_o;
	logic cmos_we_o, cmos_rd_o, scandoubler_disable_i, scandoubler_en_o;

	int wfr_cnt = 0;
	int rc_cnt = 0;
	int rst_cnt = 0;
	int cycle_cnt = 0;
	int seed_val;

	archimedes_board_glue dut (.*);

	`include "tb_checks.svh"

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// counts the pll strobes, sampled on the rising edge
	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (pll_write_from_rom_o)
			wfr_cnt++;
		if (pll_reconfig_o)
			rc_cnt++;
		if (pll_reconfig_reset_o)
			rst_cnt++;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD);
		$display("error: watchdog expired after %0d cycles, a test hung", TOTAL_CYCLES);
		abort_run();
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic init_inputs();
		clk_sel_i = CLK_24M;
		pll_busy_i = 1'b0;
		ce_pix_i = 1'b0;
		{core_r_i, core_g_i, core_b_i, core_hs_i, core_vs_i} = '0;
		{downloading_i, uploading_i, loader_we_i, dio_index_i} = '0;
		{loader_addr_i, loader_sel_i, loader_data_i} = '0;
		{core_we_i, core_stb_i, core_sel_i, core_addr_i, core_data_i} = '0;
		ram_ack_i = 1'b0;
		ram_ready_i = 1'b0;
		{conf_ss_n_i, dio_ss_n_i, sd_ss_n_i} = 3'b111;
		{spi_di_i, user_sdo_i, dio_sdo_i} = '0;
		joy_a_i = '0;
		joy_b_i = '0;
		scandoubler_disable_i = 1'b0;
	endtask

	task automatic reset_dut();
		@(negedge clk_sys);
		init_inputs();
		rst_i = 1'b1;
		repeat (4) @(negedge clk_sys);
		rst_i = 1'b0;
	endtask

	// polls one pll strobe on the falling edge, 0 write, 1 reconfig, 2 reset
	task automatic wait_strobe(input int which, input int limit);
		int n;
		bit seen;
		n = 0;
		seen = 0;
		while (!seen) begin
			@(negedge clk_sys);
			case (which)
			0: seen = pll_write_from_rom_o;
			1: seen = pll_reconfig_o;
			default: seen = pll_reconfig_reset_o;
			endcase
			n++;
			if (!seen && n >= limit) begin
				$display("error: pll strobe %0d did not appear within %0d cycles", which, limit);
				abort_run();
			end
		end
	endtask

	task automatic run_file_vectors();
		bit found;
		open_stim();
		next_vector(found);
		while (found) begin
			@(negedge clk_sys);
			if (vec_kind == "bus")
				apply_bus_vector();
			else if (vec_kind == "host")
				apply_host_vector();
			else begin
				$display("error: vector %s has unknown kind %s", vec_name, vec_kind);
				abort_run();
			end
			next_vector(found);
		end
		$fclose(stim_fd);
	endtask

	task automatic test_loader_strobe();
		int hold;
		logic [31:0] ldata;
		hold = $urandom_range(8, 1);
		ldata = $urandom;
		@(negedge clk_sys);
		downloading_i = 1'b1;
		dio_index_i = DIO_ROM_A;
		ram_ready_i = 1'b1;
		loader_addr_i = 24'h000101;
		loader_data_i = ldata;
		loader_we_i = 1'b1;
		@(negedge clk_sys);
		loader_we_i = 1'b0;
		check("strobe set", 1, ram_stb_o);
		check("strobe data", ldata, ram_data_o);
		check("strobe addr", 32'h100, ram_addr_o);
		// no ack yet, the strobe must hold
		repeat (hold) begin
			@(negedge clk_sys);
			check("strobe hold", 1, ram_stb_o);
			check("reset in download", 1, core_reset_o);
		end
		ram_ack_i = 1'b1;
		@(negedge clk_sys);
		ram_ack_i = 1'b0;
		check("strobe clear", 0, ram_stb_o);
		check("cycle clear", 0, ram_cyc_o);
		downloading_i = 1'b0;
		check("reset at end", 1, core_reset_o);
		@(negedge clk_sys);
		check("core released", 0, core_reset_o);
	endtask

	task automatic test_reconfig();
		int wfr0, rc0, rst0;
		@(negedge clk_sys);
		wfr0 = wfr_cnt;
		rc0 = rc_cnt;
		rst0 = rst_cnt;
		pll_busy_i = 1'b1;
		clk_sel_i = CLK_25M;
		wait_strobe(0, 20);
		repeat (30) @(negedge clk_sys);
		check("reconfig held by busy", rc0, rc_cnt);
		pll_busy_i = 1'b0;
		wait_strobe(1, 20);
		repeat (200) @(negedge clk_sys);
		check("write pulse count", wfr0 + 1, wfr_cnt);
		check("reconfig pulse count", rc0 + 1, rc_cnt);
		check("no timeout reset", rst0, rst_cnt);
	endtask

	task automatic test_timeout();
		int t_rc;
		@(negedge clk_sys);
		clk_sel_i = CLK_36M;
		wait_strobe(1, 20);
		t_rc = cycle_cnt;
		// busy goes up while the reconfigure pulse is still high
		pll_busy_i = 1'b1;
		wait_strobe(2, RECONFIG_TIMEOUT + 20);
		check("timeout distance", RECONFIG_TIMEOUT, cycle_cnt - t_rc);
		pll_busy_i = 1'b0;
		clk_sel_i = CLK_24M_ALT;
		wait_strobe(0, 20);
		wait_strobe(1, 20);
	endtask

	// random pixel enable gaps, syncs must move only on enabled cycles
	task automatic test_sync_delay();
		logic exp_hs, exp_vs;
		exp_hs = 1'b0;
		exp_vs = 1'b0;
		repeat (40) begin
			@(negedge clk_sys);
			check("hs delay", exp_hs, vid_hs_o);
			check("vs delay", exp_vs, vid_vs_o);
			ce_pix_i = $urandom_range(1, 0);
			core_hs_i = $urandom_range(1, 0);
			core_vs_i = $urandom_range(1, 0);
			if (ce_pix_i) begin
				exp_hs = core_hs_i;
				exp_vs = core_vs_i;
			end
		end
	endtask

	task automatic test_blank_window(input clksel_t sel, input bit vga);
		@(negedge clk_sys);
		clk_sel_i = sel;
		ce_pix_i = 1'b1;
		core_hs_i = 1'b0;
		core_vs_i = 1'b1;
		{core_r_i, core_g_i, core_b_i} = 12'h5a3;
		repeat (4) @(negedge clk_sys);
		core_hs_i = 1'b1;
		for (int i = 1; i <= 270; i++) begin
			@(negedge clk_sys);
			if (i == 10) begin
				check("blank early", 0, {vid_r_o, vid_g_o, vid_b_o});
				check("hs follows", 1, vid_hs_o);
				check("vs follows", 1, vid_vs_o);
			end
			if (i == 80)
				check("blank at 80", vga ? 12'h5a3 : 12'h0, {vid_r_o, vid_g_o, vid_b_o});
			if (i == 270)
				check("colour late", 12'h5a3, {vid_r_o, vid_g_o, vid_b_o});
		end
	endtask

	initial begin
		seed_val = $urandom(32'hbe8d);
		clk_sys = 1'b0;
		rst_i = 1'b1;
		init_inputs();
		reset_dut();
		run_file_vectors();
		reset_dut();
		test_loader_strobe();
		test_reconfig();
		test_timeout();
		reset_dut();
		test_sync_delay();
		test_blank_window(CLK_25M, 1'b1);
		test_blank_window(CLK_24M, 1'b0);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: tb/stim_input.txt
# bus: name bus dl idx laddr lsel caddr csel cwe cstb | addr sel we stb ack src (1 loader)
# host: name host conf dio sd di usdo dsdo joya joyb dl ul idx we sel sdis
#       | spi_do oe sd_sdi joy0 joy1 cmos_we cmos_rd sd_en
bus_rom_a    bus 1 01 123457 f 00abcd 3 0 1 0123454 f 1 0 0 1
bus_rom_b    bus 1 02 fffffe 1 000010 2 0 1 0fffffc 1 1 0 0 1
bus_cmos     bus 1 03 111111 8 abcdef 6 1 1 0abcdec 6 1 1 1 0
bus_idx0     bus 1 00 222222 4 000003 c 0 0 0000000 c 0 0 1 0
bus_idle_a   bus 0 01 333333 2 7ffffd 9 1 1 07ffffc 9 1 1 1 0
bus_idle_b   bus 0 02 444444 1 800001 5 0 0 0800000 5 0 0 1 0
host_user    host 0 1 1 0 1 0 01 10 0 0 00 0 0 0 1 1 0 0f 17 0 0 1
host_both    host 0 0 0 1 0 1 ff 00 1 0 03 1 1 0 0 1 0 1f 00 1 0 0
host_dio     host 1 0 0 0 0 1 02 08 1 1 03 0 2 0 1 1 1 1e 1b 0 1 0
host_none    host 1 1 1 1 1 1 04 e0 0 1 02 1 3 0 0 0 1 1f 1d 0 0 1
host_sd_dis  host 1 1 0 1 0 0 00 ff 1 0 01 1 3 1 0 0 0 00 1f 0 0 0
host_tv_dis  host 0 1 1 1 0 0 10 01 0 0 00 0 0 1 0 1 1 17 0f 0 0 0

// File: project.f
+incdir+tb
rtl/board_pkg.sv
rtl/pll_reconfig_seq.sv
rtl/back_porch_blank.sv
rtl/loader_mem_arb.sv
rtl/mist_io_glue.sv
rtl/archimedes_board_glue.sv
tb/tb_archimedes_board_glue.sv

// File: Bender.yml
package:
  name: archimedes_board_glue

sources:
  - rtl/board_pkg.sv
  - rtl/pll_reconfig_seq.sv
  - rtl/back_porch_blank.sv
  - rtl/loader_mem_arb.sv
  - rtl/mist_io_glue.sv
  - rtl/archimedes_board_glue.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_archimedes_board_glue.sv
